// File: src/axi_types_pkg.sv
package axi_types_pkg;

    typedef logic [3:0]  axi_id_t;
    typedef logic [31:0] axi_addr_t;
    typedef logic [31:0] axi_data_t;
    typedef logic [3:0]  axi_strb_t;
    typedef logic [2:0]  axi_size_t;
    typedef logic [7:0]  axi_len_t;
    typedef logic [1:0]  axi_burst_t;
    typedef logic [1:0]  axi_lock_t;
    typedef logic [3:0]  axi_cache_t;
    typedef logic [2:0]  axi_prot_t;

    // one id per requesting port
    localparam axi_id_t ID_INST = 4'd0;
    localparam axi_id_t ID_DATA = 4'd1;

    // single-beat transfers only
    localparam axi_len_t   AXI_LEN_SINGLE  = 8'd0;
    localparam axi_burst_t AXI_BURST_INCR  = 2'b01;
    localparam axi_lock_t  AXI_LOCK_NORMAL = 2'b00;
    localparam axi_cache_t AXI_CACHE_NONE  = 4'b0000;
    localparam axi_prot_t  AXI_PROT_NONE   = 3'b000;

    typedef struct packed {
        axi_id_t   arid;
        axi_addr_t araddr;
        axi_size_t arsize;
    } axi_ar_t;

    typedef struct packed {
        axi_id_t   rid;
        axi_data_t rdata;
        logic      rlast;
    } axi_r_t;

    typedef struct packed {
        axi_id_t   awid;
        axi_addr_t awaddr;
        axi_size_t awsize;
    } axi_aw_t;

    typedef struct packed {
        axi_data_t wdata;
        axi_strb_t wstrb;
        logic      wlast;
    } axi_w_t;

endpackage

// File: src/sram_if_pkg.sv
package sram_if_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;

    // log2 of the byte count: 0 byte, 1 half, 2 word
    typedef logic [1:0] sram_size_t;

    typedef logic [3:0] sram_strb_t;

    // request as captured at acceptance
    typedef struct packed {
        logic       wr;
        sram_size_t size;
        sram_strb_t wstrb;
        addr_t      addr;
        word_t      wdata;
    } sram_req_t;

    // completion back toward the processor
    typedef struct packed {
        logic  data_ok;
        word_t rdata;
    } sram_rsp_t;

endpackage

// File: src/sram_port_ctrl.sv
module sram_port_ctrl (
    input  logic                   clk,
    input  logic                   resetn,
    input  logic                   req,
    input  logic                   wr,
    input  sram_if_pkg::sram_size_t size,
    input  sram_if_pkg::sram_strb_t wstrb,
    input  sram_if_pkg::addr_t      addr,
    input  sram_if_pkg::word_t      wdata,
    output logic                   addr_ok,
    output logic                   data_ok,
    output sram_if_pkg::word_t      rdata,
    output sram_if_pkg::sram_req_t  pend,
    output logic                   pend_valid,
    input  logic                   grant,
    input  logic                   done,
    input  sram_if_pkg::word_t      done_data
);
    import sram_if_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ISSUE,
        ST_WAIT
    } state_t;

    state_t    state_q;
    state_t    state_d;
    sram_rsp_t rsp;

    // only one request per port at a time
    assign addr_ok    = (state_q == ST_IDLE);
    assign pend_valid = (state_q == ST_ISSUE);

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (req) begin
                    state_d = ST_ISSUE;
                end
            end
            ST_ISSUE: begin
                if (grant) begin
                    state_d = ST_WAIT;
                end
            end
            ST_WAIT: begin
                if (done) begin
                    state_d = ST_IDLE;
                end
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // held stable until granted
    always_ff @(posedge clk) begin
        if (req && addr_ok) begin
            pend <= '{wr: wr, size: size, wstrb: wstrb, addr: addr, wdata: wdata};
        end
    end

    // completion passes straight through in the done cycle
    assign rsp.data_ok = (state_q == ST_WAIT) && done;
    assign rsp.rdata   = done_data;

    assign data_ok = rsp.data_ok;
    assign rdata   = rsp.rdata;

endmodule

// File: src/ar_arbiter.sv
module ar_arbiter (
    input  logic                   clk,
    input  logic                   resetn,
    input  sram_if_pkg::sram_req_t  inst_pend,
    input  logic                   inst_pend_valid,
    output logic                   inst_grant,
    output logic                   inst_done,
    input  sram_if_pkg::sram_req_t  data_pend,
    input  logic                   data_pend_valid,
    output logic                   data_grant,
    output logic                   data_done,
    output sram_if_pkg::word_t      rdata_out,
    output axi_types_pkg::axi_ar_t  ar,
    output logic                   arvalid,
    input  logic                   arready,
    input  axi_types_pkg::axi_r_t   r,
    input  logic                   rvalid,
    output logic                   rready
);
    import sram_if_pkg::*;
    import axi_types_pkg::*;

    // one-hot states
    localparam logic [2:0] AR_WAIT      = 3'b001;
    localparam logic [2:0] AR_INST_SEND = 3'b010;
    localparam logic [2:0] AR_DATA_SEND = 3'b100;

    logic [2:0] ar_state_q;
    logic [2:0] ar_state_d;
    logic       ar_fire;
    logic       load_inst;
    logic       load_data;
    logic       r_beat;

    assign ar_fire = arvalid && arready;

    // instruction port has priority from wait
    assign load_inst = (ar_state_q == AR_WAIT) && inst_pend_valid;
    // data follows directly behind an instruction send
    assign load_data = ((ar_state_q == AR_WAIT) && !inst_pend_valid && data_pend_valid)
                    || ((ar_state_q == AR_INST_SEND) && arready && data_pend_valid);

    always_comb begin
        ar_state_d = ar_state_q;
        case (ar_state_q)
            AR_WAIT: begin
                if (inst_pend_valid) begin
                    ar_state_d = AR_INST_SEND;
                end else if (data_pend_valid) begin
                    ar_state_d = AR_DATA_SEND;
                end
            end
            AR_INST_SEND: begin
                if (arready && data_pend_valid) begin
                    ar_state_d = AR_DATA_SEND;
                end else if (arready) begin
                    ar_state_d = AR_WAIT;
                end
            end
            AR_DATA_SEND: begin
                if (arready) begin
                    ar_state_d = AR_WAIT;
                end
            end
            default: ar_state_d = AR_WAIT;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            ar_state_q <= AR_WAIT;
        end else begin
            ar_state_q <= ar_state_d;
        end
    end

    // beat payload, loaded one cycle ahead of arvalid
    always_ff @(posedge clk) begin
        if (load_inst) begin
            ar <= '{arid: ID_INST, araddr: inst_pend.addr, arsize: {1'b0, inst_pend.size}};
        end else if (load_data) begin
            ar <= '{arid: ID_DATA, araddr: data_pend.addr, arsize: {1'b0, data_pend.size}};
        end
    end

    assign arvalid    = (ar_state_q != AR_WAIT);
    assign inst_grant = ar_fire && (ar_state_q == AR_INST_SEND);
    assign data_grant = ar_fire && (ar_state_q == AR_DATA_SEND);

    // responses steered back by rid
    assign rready    = 1'b1;
    assign r_beat    = rvalid && r.rlast;
    assign inst_done = r_beat && (r.rid == ID_INST);
    assign data_done = r_beat && (r.rid == ID_DATA);
    assign rdata_out = r.rdata;

endmodule

// File: src/aw_w_channel.sv
module aw_w_channel (
    input  logic                   clk,
    input  logic                   resetn,
    input  sram_if_pkg::sram_req_t  pend,
    input  logic                   pend_valid,
    output logic                   grant,
    output logic                   done,
    output axi_types_pkg::axi_aw_t  aw,
    output logic                   awvalid,
    input  logic                   awready,
    output axi_types_pkg::axi_w_t   w,
    output logic                   wvalid,
    input  logic                   wready,
    input  logic                   bvalid,
    output logic                   bready
);
    import axi_types_pkg::*;

    typedef enum logic [1:0] {
        WR_IDLE,
        WR_SEND,
        WR_RESP
    } wr_state_t;

    wr_state_t wr_state_q;
    logic      aw_sent;
    logic      w_sent;
    logic      aw_fire;
    logic      w_fire;

    assign aw_fire = awvalid && awready;
    assign w_fire  = wvalid && wready;

    // each channel drops on its own handshake
    assign awvalid = (wr_state_q == WR_SEND) && !aw_sent;
    assign wvalid  = (wr_state_q == WR_SEND) && !w_sent;

    // both halves through, in either order
    assign grant = (wr_state_q == WR_SEND) && (aw_sent || aw_fire) && (w_sent || w_fire);

    assign bready = (wr_state_q == WR_RESP);
    assign done   = bready && bvalid;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            wr_state_q <= WR_IDLE;
            aw_sent    <= 1'b0;
            w_sent     <= 1'b0;
        end else begin
            case (wr_state_q)
                WR_IDLE: begin
                    if (pend_valid) begin
                        wr_state_q <= WR_SEND;
                        aw_sent    <= 1'b0;
                        w_sent     <= 1'b0;
                    end
                end
                WR_SEND: begin
                    if (aw_fire) begin
                        aw_sent <= 1'b1;
                    end
                    if (w_fire) begin
                        w_sent <= 1'b1;
                    end
                    if (grant) begin
                        wr_state_q <= WR_RESP;
                    end
                end
                WR_RESP: begin
                    if (done) begin
                        wr_state_q <= WR_IDLE;
                    end
                end
                default: wr_state_q <= WR_IDLE;
            endcase
        end
    end

    // wdata goes out lane-aligned as the processor gave it
    always_ff @(posedge clk) begin
        if (wr_state_q == WR_IDLE && pend_valid) begin
            aw <= '{awid: ID_DATA, awaddr: pend.addr, awsize: {1'b0, pend.size}};
            w  <= '{wdata: pend.wdata, wstrb: pend.wstrb, wlast: 1'b1};
        end
    end

endmodule

// File: src/axi_sram_bridge.sv
module axi_sram_bridge (
    input  logic                    clk,
    input  logic                    resetn,
    input  logic                    inst_req,
    input  logic                    inst_wr,
    input  sram_if_pkg::sram_size_t  inst_size,
    input  sram_if_pkg::sram_strb_t  inst_wstrb,
    input  sram_if_pkg::addr_t       inst_addr,
    input  sram_if_pkg::word_t       inst_wdata,
    output logic                    inst_addr_ok,
    output logic                    inst_data_ok,
    output sram_if_pkg::word_t       inst_rdata,
    input  logic                    data_req,
    input  logic                    data_wr,
    input  sram_if_pkg::sram_size_t  data_size,
    input  sram_if_pkg::sram_strb_t  data_wstrb,
    input  sram_if_pkg::addr_t       data_addr,
    input  sram_if_pkg::word_t       data_wdata,
    output logic                    data_addr_ok,
    output logic                    data_data_ok,
    output sram_if_pkg::word_t       data_rdata,
    output axi_types_pkg::axi_ar_t   ar,
    output axi_types_pkg::axi_len_t  arlen,
    output axi_types_pkg::axi_burst_t arburst,
    output axi_types_pkg::axi_lock_t arlock,
    output axi_types_pkg::axi_cache_t arcache,
    output axi_types_pkg::axi_prot_t arprot,
    output logic                    arvalid,
    input  logic                    arready,
    input  axi_types_pkg::axi_r_t    r,
    input  logic                    rvalid,
    output logic                    rready,
    output axi_types_pkg::axi_aw_t   aw,
    output axi_types_pkg::axi_len_t  awlen,
    output axi_types_pkg::axi_burst_t awburst,
    output axi_types_pkg::axi_lock_t awlock,
    output axi_types_pkg::axi_cache_t awcache,
    output axi_types_pkg::axi_prot_t awprot,
    output logic                    awvalid,
    input  logic                    awready,
    output axi_types_pkg::axi_w_t    w,
    output logic                    wvalid,
    input  logic                    wready,
    input  logic                    bvalid,
    output logic                    bready
);
    import sram_if_pkg::*;
    import axi_types_pkg::*;

    sram_req_t inst_pend;
    sram_req_t data_pend;
    logic      inst_pend_valid;
    logic      data_pend_valid;
    logic      inst_grant;
    logic      inst_done;
    logic      data_grant;
    logic      data_done;
    logic      data_rd_valid;
    logic      data_wr_valid;
    logic      ar_data_grant;
    logic      ar_data_done;
    logic      wr_grant;
    logic      wr_done;
    word_t     rd_word;

    // every beat is a plain single transfer
    assign arlen   = AXI_LEN_SINGLE;
    assign arburst = AXI_BURST_INCR;
    assign arlock  = AXI_LOCK_NORMAL;
    assign arcache = AXI_CACHE_NONE;
    assign arprot  = AXI_PROT_NONE;
    assign awlen   = AXI_LEN_SINGLE;
    assign awburst = AXI_BURST_INCR;
    assign awlock  = AXI_LOCK_NORMAL;
    assign awcache = AXI_CACHE_NONE;
    assign awprot  = AXI_PROT_NONE;

    // data port steered by its wr bit, inst port only ever reads
    assign data_rd_valid = data_pend_valid && !data_pend.wr;
    assign data_wr_valid = data_pend_valid && data_pend.wr;
    assign data_grant    = data_pend.wr ? wr_grant : ar_data_grant;
    assign data_done     = data_pend.wr ? wr_done : ar_data_done;

    sram_port_ctrl inst_port0 (
        .clk       (clk),
        .resetn    (resetn),
        .req       (inst_req),
        .wr        (inst_wr),
        .size      (inst_size),
        .wstrb     (inst_wstrb),
        .addr      (inst_addr),
        .wdata     (inst_wdata),
        .addr_ok   (inst_addr_ok),
        .data_ok   (inst_data_ok),
        .rdata     (inst_rdata),
        .pend      (inst_pend),
        .pend_valid(inst_pend_valid),
        .grant     (inst_grant),
        .done      (inst_done),
        .done_data (rd_word)
    );

    sram_port_ctrl data_port0 (
        .clk       (clk),
        .resetn    (resetn),
        .req       (data_req),
        .wr        (data_wr),
        .size      (data_size),
        .wstrb     (data_wstrb),
        .addr      (data_addr),
        .wdata     (data_wdata),
        .addr_ok   (data_addr_ok),
        .data_ok   (data_data_ok),
        .rdata     (data_rdata),
        .pend      (data_pend),
        .pend_valid(data_pend_valid),
        .grant     (data_grant),
        .done      (data_done),
        .done_data (rd_word)
    );

    ar_arbiter ar_arb0 (
        .clk            (clk),
        .resetn         (resetn),
        .inst_pend      (inst_pend),
        .inst_pend_valid(inst_pend_valid),
        .inst_grant     (inst_grant),
        .inst_done      (inst_done),
        .data_pend      (data_pend),
        .data_pend_valid(data_rd_valid),
        .data_grant     (ar_data_grant),
        .data_done      (ar_data_done),
        .rdata_out      (rd_word),
        .ar             (ar),
        .arvalid        (arvalid),
        .arready        (arready),
        .r              (r),
        .rvalid         (rvalid),
        .rready         (rready)
    );

    aw_w_channel wr_chan0 (
        .clk       (clk),
        .resetn    (resetn),
        .pend      (data_pend),
        .pend_valid(data_wr_valid),
        .grant     (wr_grant),
        .done      (wr_done),
        .aw        (aw),
        .awvalid   (awvalid),
        .awready   (awready),
        .w         (w),
        .wvalid    (wvalid),
        .wready    (wready),
        .bvalid    (bvalid),
        .bready    (bready)
    );

endmodule

// File: sim/axi_mem_slave.sv
module axi_mem_slave (
    input  logic                   clk,
    input  logic                   resetn,
    input  axi_types_pkg::axi_ar_t ar,
    input  logic                   arvalid,
    output logic                   arready,
    output axi_types_pkg::axi_r_t  r,
    output logic                   rvalid,
    input  logic                   rready,
    input  axi_types_pkg::axi_aw_t aw,
    input  logic                   awvalid,
    output logic                   awready,
    input  axi_types_pkg::axi_w_t  w,
    input  logic                   wvalid,
    output logic                   wready,
    output logic                   bvalid,
    input  logic                   bready
);
    import axi_types_pkg::*;

    axi_data_t  mem [0:1023];
    axi_ar_t    rd_q [$];
    axi_ar_t    ar_head;
    axi_aw_t    aw_hold;
    axi_w_t     w_hold;
    logic       have_aw;
    logic       have_w;
    logic [2:0] ar_wait;
    logic [2:0] aw_wait;
    logic [2:0] w_wait;
    logic [2:0] r_wait;
    logic [2:0] b_wait;
    integer     seed = 81603;

    // 0 to 5 cycles
    function automatic logic [2:0] delay_draw();
        logic [31:0] draw;
        draw = $random(seed);
        return 3'(draw % 6);
    endfunction

    assign arready = (ar_wait == 3'd0);
    assign awready = (aw_wait == 3'd0) && !have_aw;
    assign wready  = (w_wait == 3'd0) && !have_w;

    // all draws in one block so the random sequence is fixed
    always @(posedge clk) begin
        if (!resetn) begin
            ar_wait <= 3'd0;
            aw_wait <= 3'd0;
            w_wait  <= 3'd0;
            r_wait  <= 3'd0;
            b_wait  <= 3'd0;
            rvalid  <= 1'b0;
            bvalid  <= 1'b0;
            have_aw <= 1'b0;
            have_w  <= 1'b0;
            rd_q.delete();
        end else begin
            // reads answered in order of acceptance
            if (rvalid && rready) begin
                rvalid <= 1'b0;
            end else if (!rvalid && rd_q.size() != 0) begin
                if (r_wait == 3'd0) begin
                    ar_head = rd_q.pop_front();
                    r      <= '{rid: ar_head.arid, rdata: mem[ar_head.araddr[11:2]], rlast: 1'b1};
                    rvalid <= 1'b1;
                    r_wait <= delay_draw();
                end else begin
                    r_wait <= r_wait - 3'd1;
                end
            end
            if (arvalid && arready) begin
                rd_q.push_back(ar);
                ar_wait <= delay_draw();
            end else if (arvalid && ar_wait != 3'd0) begin
                ar_wait <= ar_wait - 3'd1;
            end
            // address and data taken independently
            if (awvalid && awready) begin
                aw_hold <= aw;
                have_aw <= 1'b1;
                aw_wait <= delay_draw();
            end else if (awvalid && aw_wait != 3'd0) begin
                aw_wait <= aw_wait - 3'd1;
            end
            if (wvalid && wready) begin
                w_hold <= w;
                have_w <= 1'b1;
                w_wait <= delay_draw();
            end else if (wvalid && w_wait != 3'd0) begin
                w_wait <= w_wait - 3'd1;
            end
            if (bvalid && bready) begin
                bvalid <= 1'b0;
            end else if (!bvalid && have_aw && have_w) begin
                if (b_wait == 3'd0) begin
                    for (int k = 0; k < 4; k++) begin
                        if (w_hold.wstrb[k]) begin
                            mem[aw_hold.awaddr[11:2]][8*k +: 8] = w_hold.wdata[8*k +: 8];
                        end
                    end
                    bvalid  <= 1'b1;
                    have_aw <= 1'b0;
                    have_w  <= 1'b0;
                    b_wait  <= delay_draw();
                end else begin
                    b_wait <= b_wait - 3'd1;
                end
            end
        end
    end

endmodule

// File: sim/tb_axi_sram_bridge.sv
module tb_axi_sram_bridge;
    import sram_if_pkg::*;
    import axi_types_pkg::*;

    localparam int N_INST_SEQ  = 16;
    localparam int N_WR        = 8;
    localparam int N_PAIR      = 4;
    localparam int N_RAND      = 100;
    localparam int TOTAL_REQ   = N_INST_SEQ + 2 * N_WR + 2 * N_PAIR + 2 * N_RAND;
    localparam int CYCLE_LIMIT = 40 * TOTAL_REQ;

    typedef struct packed {
        logic  wr;
        addr_t addr;
    } data_op_t;

    // fixed attributes carried by every address beat
    typedef struct packed {
        axi_len_t   len;
        axi_burst_t burst;
        axi_lock_t  lock;
        axi_cache_t cache;
        axi_prot_t  prot;
        axi_size_t  size;
    } beat_attr_t;

    logic       clk;
    logic       resetn;
    logic       inst_req, inst_wr, inst_addr_ok, inst_data_ok;
    sram_size_t inst_size;
    sram_strb_t inst_wstrb;
    addr_t      inst_addr;
    word_t      inst_wdata, inst_rdata;
    logic       data_req, data_wr, data_addr_ok, data_data_ok;
    sram_size_t data_size;
    sram_strb_t data_wstrb;
    addr_t      data_addr;
    word_t      data_wdata, data_rdata;
    axi_ar_t    ar;
    axi_r_t     r;
    axi_aw_t    aw;
    axi_w_t     w;
    axi_len_t   arlen, awlen;
    axi_burst_t arburst, awburst;
    axi_lock_t  arlock, awlock;
    axi_cache_t arcache, awcache;
    axi_prot_t  arprot, awprot;
    logic       arvalid, arready, rvalid, rready;
    logic       awvalid, awready, wvalid, wready, bvalid, bready;

    word_t       shadow [0:1023];
    addr_t       inst_q [$];
    data_op_t    data_q [$];
    axi_id_t     ar_order [$];
    int          inst_accepted, inst_completed, data_accepted, data_completed;
    int          cycle_count;
    integer      seed;
    logic [31:0] rv;
    string       test_name;
    sram_size_t  exp_wr_size;
    addr_t       rnd_inst_addr [N_RAND];
    data_op_t    rnd_data_op [N_RAND];
    sram_strb_t  rnd_strb [N_RAND];
    word_t       rnd_wdata [N_RAND];

    axi_sram_bridge dut0 (.*);
    axi_mem_slave   mem0 (.*);

    always #4 clk = ~clk;

    // every index bit shows up in both halves
    function automatic word_t pattern_word(input int idx);
        return {6'h2b, idx[9:0], 6'h15, ~idx[9:0]};
    endfunction

    function automatic word_t predicted_word(input addr_t a);
        return shadow[a[11:2]];
    endfunction

    function automatic sram_strb_t strobe_pick(input logic [2:0] n);
        return (n < 3'd2) ? 4'hF : (n == 3'd2) ? 4'h3 : (n == 3'd3) ? 4'hC : 4'(1 << n[1:0]);
    endfunction

    function automatic sram_size_t size_for(input sram_strb_t strb);
        return ($countones(strb) == 4) ? 2'd2 : ($countones(strb) == 2) ? 2'd1 : 2'd0;
    endfunction

    task automatic apply_write(input addr_t a, input sram_strb_t strb, input word_t wd);
        for (int k = 0; k < 4; k++) begin
            if (strb[k]) begin
                shadow[a[11:2]][8*k +: 8] = wd[8*k +: 8];
            end
        end
    endtask

    task automatic check_rdata(input string name, input word_t exp, input word_t act);
        if (exp !== act) begin
            $display("ERR %s expected %h actual %h", name, exp, act);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    task automatic check_done_count(input string name, input int exp, input int act);
        if (exp !== act) begin
            $display("ERR %s expected %0d actual %0d", name, exp, act);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    task automatic check_id(input string name, input axi_id_t exp, input axi_id_t act);
        if (exp !== act) begin
            $display("ERR %s expected %0d actual %0d", name, exp, act);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("ERR %s expected %b actual %b", name, exp, act);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    task automatic check_attr(input string name, input beat_attr_t exp, input beat_attr_t act);
        if (exp !== act) begin
            $display("ERR %s expected %h actual %h", name, exp, act);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    // accepted at the edge where req and addr_ok were both high
    task automatic inst_read(input addr_t a);
        @(posedge clk);
        inst_req  <= 1'b1;
        inst_addr <= a;
        inst_size <= 2'd2;
        @(posedge clk);
        while (!inst_addr_ok) begin
            @(posedge clk);
        end
        inst_req <= 1'b0;
        inst_q.push_back(a);
        inst_accepted++;
    endtask

    task automatic data_access(input logic wr, input addr_t a, input sram_strb_t strb,
                               input word_t wd);
        data_op_t op;
        @(posedge clk);
        data_req   <= 1'b1;
        data_wr    <= wr;
        data_addr  <= a;
        data_wstrb <= strb;
        data_wdata <= wd;
        data_size  <= wr ? size_for(strb) : 2'd2;
        @(posedge clk);
        while (!data_addr_ok) begin
            @(posedge clk);
        end
        data_req <= 1'b0;
        if (wr) begin
            apply_write(a, strb, wd);
            exp_wr_size = size_for(strb);
        end
        op.wr   = wr;
        op.addr = a;
        data_q.push_back(op);
        data_accepted++;
    endtask

    // a port only returns to idle once its request has finished
    task automatic wait_ports_idle();
        @(negedge clk);
        while (!inst_addr_ok || !data_addr_ok) begin
            @(negedge clk);
        end
    endtask

    always @(posedge clk) begin : inst_compare
        addr_t a;
        if (resetn && inst_data_ok) begin
            if (inst_q.size() == 0) begin
                $display("instruction port completed a request that was never accepted");
                $display("Test failed");
                $fatal(1);
            end else begin
                a = inst_q.pop_front();
                check_rdata(test_name, predicted_word(a), inst_rdata);
                inst_completed++;
            end
        end
    end

    always @(posedge clk) begin : data_compare
        data_op_t op;
        if (resetn && data_data_ok) begin
            if (data_q.size() == 0) begin
                $display("data port completed a request that was never accepted");
                $display("Test failed");
                $fatal(1);
            end else begin
                op = data_q.pop_front();
                if (!op.wr) begin
                    check_rdata(test_name, predicted_word(op.addr), data_rdata);
                end
                data_completed++;
            end
        end
    end

    // single-beat attributes on each handshake
    always @(posedge clk) begin : beat_compare
        beat_attr_t exp_attr;
        beat_attr_t act_attr;
        exp_attr.len   = 8'd0;
        exp_attr.burst = 2'b01;
        exp_attr.lock  = 2'b00;
        exp_attr.cache = 4'h0;
        exp_attr.prot  = 3'd0;
        exp_attr.size  = 3'd2;
        if (resetn && arvalid && arready) begin
            act_attr = {arlen, arburst, arlock, arcache, arprot, ar.arsize};
            check_attr("ar_attr", exp_attr, act_attr);
        end
        if (resetn && awvalid && awready) begin
            exp_attr.size = {1'b0, exp_wr_size};
            act_attr = {awlen, awburst, awlock, awcache, awprot, aw.awsize};
            check_attr("aw_attr", exp_attr, act_attr);
            check_id("awid", ID_DATA, aw.awid);
        end
        if (resetn && wvalid && wready) begin
            check_flag("wlast", 1'b1, w.wlast);
        end
        if (resetn && rvalid) begin
            check_flag("rready", 1'b1, rready);
        end
    end

    // order of AR handshakes by id
    always @(posedge clk) begin
        if (resetn && arvalid && arready) begin
            ar_order.push_back(ar.arid);
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > CYCLE_LIMIT) begin
            $display("timeout after %0d cycles with requests still outstanding", cycle_count);
            $display("Test failed");
            $fatal(1);
        end
    end

    initial begin
        seed           = 81603;
        clk            = 1'b0;
        resetn         = 1'b0;
        cycle_count    = 0;
        inst_accepted  = 0;
        inst_completed = 0;
        data_accepted  = 0;
        data_completed = 0;
        exp_wr_size    = 2'd2;
        inst_req       = 1'b0;
        inst_wr        = 1'b0;
        inst_size      = 2'd2;
        inst_wstrb     = 4'h0;
        inst_addr      = '0;
        inst_wdata     = '0;
        data_req       = 1'b0;
        data_wr        = 1'b0;
        data_size      = 2'd2;
        data_wstrb     = 4'h0;
        data_addr      = '0;
        data_wdata     = '0;
        for (int i = 0; i < 1024; i++) begin
            mem0.mem[i] = pattern_word(i);
            shadow[i]   = pattern_word(i);
        end
        repeat (10) @(posedge clk);
        resetn <= 1'b1;

        test_name = "idle";
        repeat (8) begin
            @(negedge clk);
            check_flag("idle_arvalid", 1'b0, arvalid);
            check_flag("idle_awvalid", 1'b0, awvalid);
            check_flag("idle_wvalid", 1'b0, wvalid);
            check_flag("idle_bready", 1'b0, bready);
            check_flag("idle_rready", 1'b1, rready);
            check_flag("idle_inst_data_ok", 1'b0, inst_data_ok);
            check_flag("idle_data_data_ok", 1'b0, data_data_ok);
            check_flag("idle_inst_addr_ok", 1'b1, inst_addr_ok);
            check_flag("idle_data_addr_ok", 1'b1, data_addr_ok);
        end

        test_name = "inst_seq";
        for (int i = 0; i < N_INST_SEQ; i++) begin
            inst_read(addr_t'(i * 4));
        end
        wait_ports_idle();
        check_done_count("inst_seq_done", N_INST_SEQ, inst_completed);

        // writes to words 600 and up, then read back
        test_name = "write_read";
        for (int i = 0; i < N_WR; i++) begin
            data_access(1'b1, addr_t'((600 + i) * 4), strobe_pick(3'(i)),
                        32'hD0C0_0000 + 32'(i * 32'h0001_0203));
        end
        for (int i = 0; i < N_WR; i++) begin
            data_access(1'b0, addr_t'((600 + i) * 4), 4'h0, '0);
        end
        wait_ports_idle();
        check_done_count("write_read_done", 2 * N_WR, data_completed);

        test_name = "same_cycle";
        for (int i = 0; i < N_PAIR; i++) begin
            ar_order.delete();
            fork
                inst_read(addr_t'((40 + i) * 4));
                data_access(1'b0, addr_t'((600 + i) * 4), 4'h0, '0);
            join
            wait_ports_idle();
            check_done_count("same_cycle_ar_beats", 2, ar_order.size());
            check_id("same_cycle_first_ar", ID_INST, ar_order[0]);
        end

        // inst stays below word 512, data above, so the streams never overlap
        test_name = "random_mix";
        for (int i = 0; i < N_RAND; i++) begin
            rv = $random(seed);
            rnd_inst_addr[i] = {20'd0, 1'b0, rv[8:0], 2'b00};
            rv = $random(seed);
            rnd_data_op[i].wr   = rv[0];
            rnd_data_op[i].addr = {20'd0, 1'b1, rv[9:1], 2'b00};
            rnd_strb[i]         = strobe_pick(rv[12:10]);
            rnd_wdata[i]        = $random(seed);
        end
        fork
            begin
                for (int i = 0; i < N_RAND; i++) begin
                    inst_read(rnd_inst_addr[i]);
                end
            end
            begin
                for (int i = 0; i < N_RAND; i++) begin
                    data_access(rnd_data_op[i].wr, rnd_data_op[i].addr, rnd_strb[i],
                                rnd_wdata[i]);
                end
            end
        join
        wait_ports_idle();
        check_done_count("random_mix_inst", inst_accepted, inst_completed);
        check_done_count("random_mix_data", data_accepted, data_completed);
        check_done_count("total_completions", TOTAL_REQ, inst_completed + data_completed);

        $display("Test completed successfully");
        $finish;
    end

endmodule

// File: axi_sram_bridge.f
src/axi_types_pkg.sv
src/sram_if_pkg.sv
src/sram_port_ctrl.sv
src/ar_arbiter.sv
src/aw_w_channel.sv
src/axi_sram_bridge.sv
sim/axi_mem_slave.sv
sim/tb_axi_sram_bridge.sv

// File: Bender.yml
package:
  name: axi_sram_bridge

sources:
  - src/axi_types_pkg.sv
  - src/sram_if_pkg.sv
  - src/sram_port_ctrl.sv
  - src/ar_arbiter.sv
  - src/aw_w_channel.sv
  - src/axi_sram_bridge.sv
  - target: simulation
    files:
      - sim/axi_mem_slave.sv
      - sim/tb_axi_sram_bridge.sv
